// ==== hw/demod_defs.svh ====
//**********************************************************
// Widths, host address map, version number and the
// core reset hold length
//**********************************************************
`ifndef DEMOD_DEFS_SVH
`define DEMOD_DEFS_SVH

// Datapath widths
`define DAC_WIDTH 14
`define TAP_WIDTH 18

// Host word address covers bits 11 down to 1
`define ADDR_WIDTH 11
`define BUS_WIDTH  16

// Misc space sits on address bits 11:8
`define MISC_SPACE_LSB 8
`define MISC_SPACE     4'h8
`define MISC_RESET     12'h800
`define MISC_VERSION   12'h804

// Upper half of the 32 bit version word
`define VER_NUMBER 16'h0079

// Core reset cycles after the trigger ends
`define RESET_HOLD 6

`endif

// ==== hw/demodPkg.sv ====
//**********************************************************
// Demodulation mode and DAC source select types, plus the
// decode of the trellis tap select codes
//**********************************************************
package demodPkg;

  // Demodulation mode, unknown codes behave as legacy
  typedef enum logic [3:0] {
    modeLegacy = 4'h0,
    modeMultiH = 4'h6
  } demodMode_t;

  // DAC source select codes
  typedef enum logic [3:0] {
    dacExternal     = 4'h0,
    dacTrellisI     = 4'h1,
    dacTrellisQ     = 4'h2,
    dacTrellisPhErr = 4'h3,
    dacTrellisIndex = 4'h4
  } dacSelect_t;

  // True for any code that picks a trellis tap
  function automatic logic isTrellisSel(dacSelect_t sel);
    case (sel)
      dacTrellisI,
      dacTrellisQ,
      dacTrellisPhErr,
      dacTrellisIndex: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

endpackage

// ==== hw/hostBus.sv ====
//**********************************************************
// Host bus decode for the misc space: version register
// read mux and soft reset strobe
//**********************************************************
`timescale 1ns/1ps
`include "demod_defs.svh"

module hostBus (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   nCs_i,
  input  logic                   nWe_i,
  input  logic                   nRd_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  output logic [`BUS_WIDTH-1:0]  dataOut_o,
  output logic                   dataOe_o,
  output logic                   softReset_o
);

  localparam logic [`ADDR_WIDTH:0] versionAddr = `MISC_VERSION;
  localparam logic [`ADDR_WIDTH:0] resetAddr   = `MISC_RESET;
  // Lower half of the version word reads zero
  localparam logic [2*`BUS_WIDTH-1:0] versionWord = {`VER_NUMBER, {`BUS_WIDTH{1'b0}}};

  logic [`ADDR_WIDTH:0]    fullAddr;    // Byte address, bit 0 always zero
  logic                    miscSpace;
  logic                    versionHit;
  logic                    resetHit;
  logic                    busWrite;
  logic                    busWriteDly;

  assign fullAddr    = {addr_i, 1'b0};
  assign miscSpace   = (fullAddr[`ADDR_WIDTH:`MISC_SPACE_LSB] == `MISC_SPACE);
  // 32 bit registers, bit 1 picks the half
  assign versionHit  = miscSpace && (fullAddr[`ADDR_WIDTH:2] == versionAddr[`ADDR_WIDTH:2]);
  assign resetHit    = miscSpace && (fullAddr[`ADDR_WIDTH:2] == resetAddr[`ADDR_WIDTH:2]);

  //**********************************************************
  // Read path
  //**********************************************************
  assign dataOe_o = !nCs_i && !nRd_i;

  always_comb begin
    dataOut_o = '0;                   // Unmapped reads return zero
    if (versionHit) begin
      if (addr_i[0]) begin
        dataOut_o = versionWord[2*`BUS_WIDTH-1:`BUS_WIDTH];
      end else begin
        dataOut_o = versionWord[`BUS_WIDTH-1:0];
      end
    end
  end

  //**********************************************************
  // Write path
  //**********************************************************
  assign busWrite = !nCs_i && !nWe_i;

  // Pulse on the first edge of a reset write only
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      busWriteDly <= 1'b0;
      softReset_o <= 1'b0;
    end else begin
      busWriteDly <= busWrite;
      softReset_o <= busWrite && !busWriteDly && resetHit;
    end
  end

endmodule

// ==== hw/resetStretch.sv ====
//**********************************************************
// Core reset stretcher with a reloading hold counter
//**********************************************************
`timescale 1ns/1ps
`include "demod_defs.svh"

module resetStretch (
  input  logic ck933,
  input  logic rs,
  input  logic softReset_i,
  output logic coreReset_o
);

  localparam int cntWidth = $clog2(`RESET_HOLD + 1);

  logic [cntWidth-1:0] holdCnt;
  logic [cntWidth-1:0] holdNext;

  always_comb begin
    if (softReset_i) begin
      holdNext = cntWidth'(`RESET_HOLD);  // Reload on soft trigger
    end else if (holdCnt != '0) begin
      holdNext = holdCnt - 1'b1;
    end else begin
      holdNext = '0;
    end
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      holdCnt     <= cntWidth'(`RESET_HOLD);
      coreReset_o <= 1'b1;
    end else begin
      holdCnt     <= holdNext;
      coreReset_o <= (holdNext != '0);  // Registered, no decode glitches
    end
  end

  for (genvar k = 1; k <= `RESET_HOLD; k++) begin : gHoldCheck
    assert property (@(posedge ck933) disable iff (rs) softReset_i |-> ##k coreReset_o)
      else $error("coreReset_o dropped %0d cycles after soft reset", k);
  end

endmodule

// ==== hw/dacOutput.sv ====
//**********************************************************
// One DAC channel: source select, sync enabled output
// register and offset binary MSB inversion
//**********************************************************
`timescale 1ns/1ps
`include "demod_defs.svh"

module dacOutput (
  input  logic                  ck933,
  input  logic                  rs,
  input  demodPkg::demodMode_t  mode_i,
  input  demodPkg::dacSelect_t  select_i,
  input  logic [`DAC_WIDTH-1:0] extData_i,
  input  logic [`TAP_WIDTH-1:0] tap_i,
  input  logic                  tapSync_i,
  output logic [`DAC_WIDTH-1:0] dac_o
);

  import demodPkg::*;

  logic                  useTap;
  logic [`DAC_WIDTH-1:0] selData;
  logic                  selSync;

  assign useTap = (mode_i == modeMultiH) && isTrellisSel(select_i);

  // Select stage, data side
  always_ff @(posedge ck933) begin
    if (useTap) begin
      selData <= tap_i[`TAP_WIDTH-1 -: `DAC_WIDTH];  // Keep the top bits of the tap
    end else begin
      selData <= extData_i;
    end
  end

  // Select stage, sync side
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      selSync <= 1'b0;
    end else begin
      selSync <= useTap ? tapSync_i : 1'b1;  // External data updates every cycle
    end
  end

  // Output register, two's complement to offset binary
  always_ff @(posedge ck933) begin
    if (selSync) begin
      dac_o <= {~selData[`DAC_WIDTH-1], selData[`DAC_WIDTH-2:0]};
    end
  end

endmodule

// ==== hw/symbolSource.sv ====
//**********************************************************
// Symbol bit stream source: input reclock, legacy delay
// and trellis or legacy selection by mode
//**********************************************************
`timescale 1ns/1ps

module symbolSource (
  input  logic                 ck933,
  input  logic                 rs,
  input  demodPkg::demodMode_t mode_i,
  input  logic [1:0]           trellisBits_i,
  input  logic                 trellisSymEn_i,
  input  logic                 iData_i,
  input  logic                 qData_i,
  input  logic                 dataSymEn_i,
  output logic                 doutI_o,
  output logic                 doutQ_o,
  output logic                 symEn_o
);

  import demodPkg::*;

  logic       multiH;
  logic [1:0] trellisBitsIn;
  logic       trellisSymEnIn;
  logic       iDataIn;
  logic       qDataIn;
  logic       dataSymEnIn;
  logic       iLegacy;
  logic       qLegacy;
  logic       legacySymEn;

  assign multiH = (mode_i == modeMultiH);

  // Bit path
  always_ff @(posedge ck933) begin
    trellisBitsIn <= trellisBits_i;
    iDataIn       <= iData_i;
    qDataIn       <= qData_i;
    iLegacy       <= iDataIn;            // Extra legacy stage
    qLegacy       <= qDataIn;
    doutI_o       <= multiH ? trellisBitsIn[0] : iLegacy;
    doutQ_o       <= multiH ? trellisBitsIn[1] : qLegacy;
  end

  // Strobe path
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      trellisSymEnIn <= 1'b0;
      dataSymEnIn    <= 1'b0;
      legacySymEn    <= 1'b0;
      symEn_o        <= 1'b0;
    end else begin
      trellisSymEnIn <= trellisSymEn_i;
      dataSymEnIn    <= dataSymEn_i;
      legacySymEn    <= dataSymEnIn;
      symEn_o        <= multiH ? trellisSymEnIn : legacySymEn;
    end
  end

endmodule

// ==== hw/multihTop.sv ====
//**********************************************************
// MultiH demodulator top level: input reclock, host bus,
// core reset, DAC channels, symbol source, pass-throughs
//**********************************************************
`timescale 1ns/1ps
`include "demod_defs.svh"

module multihTop (
  input  logic                   ck933,
  input  logic                   rs_i,
  input  demodPkg::demodMode_t   demodMode_i,
  // Host bus
  input  logic                   nCs_i,
  input  logic                   nWe_i,
  input  logic                   nRd_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic [`BUS_WIDTH-1:0]  dataIn_i,    // Reset register has no data bits
  output logic [`BUS_WIDTH-1:0]  dataOut_o,
  output logic                   dataOe_o,
  // DAC channels
  input  demodPkg::dacSelect_t   dac0Select_i,
  input  demodPkg::dacSelect_t   dac1Select_i,
  input  demodPkg::dacSelect_t   dac2Select_i,
  input  logic [`DAC_WIDTH-1:0]  dac0Data_i,
  input  logic [`DAC_WIDTH-1:0]  dac1Data_i,
  input  logic [`DAC_WIDTH-1:0]  dac2Data_i,
  input  logic [`TAP_WIDTH-1:0]  tap0_i,
  input  logic [`TAP_WIDTH-1:0]  tap1_i,
  input  logic [`TAP_WIDTH-1:0]  tap2_i,
  input  logic                   tapSync0_i,
  input  logic                   tapSync1_i,
  input  logic                   tapSync2_i,
  output logic [`DAC_WIDTH-1:0]  dac0_o,
  output logic [`DAC_WIDTH-1:0]  dac1_o,
  output logic [`DAC_WIDTH-1:0]  dac2_o,
  output logic                   dac0Clk_o,
  output logic                   dac1Clk_o,
  output logic                   dac2Clk_o,
  output logic                   dacRst_o,
  // Symbol inputs and outputs
  input  logic [1:0]             trellisBits_i,
  input  logic                   trellisSymEn_i,
  input  logic                   iData_i,
  input  logic                   qData_i,
  input  logic                   dataSymEn_i,
  output logic                   doutI_o,
  output logic                   doutQ_o,
  output logic                   symEn_o,
  // Lock indicators
  input  logic                   bsyncLock_i,
  input  logic                   demodLock_i,
  output logic                   bsyncNLock_o,
  output logic                   demodNLock_o
);

  logic                  coreReset;
  logic                  softReset;
  logic [`DAC_WIDTH-1:0] dac0DataIn;
  logic [`DAC_WIDTH-1:0] dac1DataIn;
  logic [`DAC_WIDTH-1:0] dac2DataIn;

  //**********************************************************
  // Pass-throughs
  //**********************************************************
  assign bsyncNLock_o = bsyncLock_i;
  assign demodNLock_o = demodLock_i;
  assign dac0Clk_o    = ck933;
  assign dac1Clk_o    = ck933;
  assign dac2Clk_o    = ck933;
  assign dacRst_o     = coreReset;

  // Reclock host DAC data
  always_ff @(posedge ck933) begin
    dac0DataIn <= dac0Data_i;
    dac1DataIn <= dac1Data_i;
    dac2DataIn <= dac2Data_i;
  end

  //**********************************************************
  // Host bus and core reset
  //**********************************************************
  hostBus hostBus_inst (
    .ck933(ck933), .rs(coreReset), .nCs_i(nCs_i), .nWe_i(nWe_i), .nRd_i(nRd_i),
    .addr_i(addr_i), .dataOut_o(dataOut_o), .dataOe_o(dataOe_o), .softReset_o(softReset)
  );

  resetStretch resetStretch_inst (
    .ck933(ck933), .rs(rs_i), .softReset_i(softReset), .coreReset_o(coreReset)
  );

  //**********************************************************
  // DAC outputs and symbol stream
  //**********************************************************
  dacOutput dac0Output_inst (
    .ck933(ck933), .rs(coreReset), .mode_i(demodMode_i), .select_i(dac0Select_i),
    .extData_i(dac0DataIn), .tap_i(tap0_i), .tapSync_i(tapSync0_i), .dac_o(dac0_o)
  );

  dacOutput dac1Output_inst (
    .ck933(ck933), .rs(coreReset), .mode_i(demodMode_i), .select_i(dac1Select_i),
    .extData_i(dac1DataIn), .tap_i(tap1_i), .tapSync_i(tapSync1_i), .dac_o(dac1_o)
  );

  dacOutput dac2Output_inst (
    .ck933(ck933), .rs(coreReset), .mode_i(demodMode_i), .select_i(dac2Select_i),
    .extData_i(dac2DataIn), .tap_i(tap2_i), .tapSync_i(tapSync2_i), .dac_o(dac2_o)
  );

  symbolSource symbolSource_inst (
    .ck933(ck933), .rs(coreReset), .mode_i(demodMode_i),
    .trellisBits_i(trellisBits_i), .trellisSymEn_i(trellisSymEn_i),
    .iData_i(iData_i), .qData_i(qData_i), .dataSymEn_i(dataSymEn_i),
    .doutI_o(doutI_o), .doutQ_o(doutQ_o), .symEn_o(symEn_o)
  );

endmodule

// ==== verification/multihTopTb.sv ====
//**********************************************************
// Top testbench with clock and reset, LFSR driven stimulus,
// checking assertions and the closing result report
//**********************************************************
`timescale 1ns/1ps
`include "demod_defs.svh"

module multihTopTb;

  import demodPkg::*;

  localparam int cycleLimit = 600;
  localparam logic [`ADDR_WIDTH-1:0] resetWord    = `ADDR_WIDTH'(`MISC_RESET >> 1);
  localparam logic [`ADDR_WIDTH-1:0] versionLower = `ADDR_WIDTH'(`MISC_VERSION >> 1);
  localparam logic [`ADDR_WIDTH-1:0] versionUpper = `ADDR_WIDTH'((`MISC_VERSION >> 1) | 1);

  logic                   ck933;
  logic                   rs_i;
  demodMode_t             demodMode_i;
  logic                   nCs_i;
  logic                   nWe_i;
  logic                   nRd_i;
  logic [`ADDR_WIDTH-1:0] addr_i;
  logic [`BUS_WIDTH-1:0]  dataIn_i;
  logic [`BUS_WIDTH-1:0]  dataOut_o;
  logic                   dataOe_o;
  dacSelect_t             dacSelect [3];
  logic [`DAC_WIDTH-1:0]  dacData [3];
  logic [`TAP_WIDTH-1:0]  tap [3];
  logic                   tapSync [3];
  logic [`DAC_WIDTH-1:0]  dacOut [3];
  logic                   dacClk [3];
  logic                   dacRst_o;
  logic [1:0]             trellisBits_i;
  logic                   trellisSymEn_i;
  logic                   iData_i;
  logic                   qData_i;
  logic                   dataSymEn_i;
  logic                   doutI_o;
  logic                   doutQ_o;
  logic                   symEn_o;
  logic                   bsyncLock_i;
  logic                   demodLock_i;
  logic                   bsyncNLock_o;
  logic                   demodNLock_o;

  logic [15:0] lfsrState;
  logic [2:0]  rstHistory = '1;      // dacRst_o over the last three edges
  int          cycles = 0;
  int          readErrors = 0;
  int          resetErrors = 0;
  int          dacErrors = 0;
  int          symErrors = 0;
  int          pinErrors = 0;

  multihTop multihTop_inst (
    .ck933(ck933), .rs_i(rs_i), .demodMode_i(demodMode_i),
    .nCs_i(nCs_i), .nWe_i(nWe_i), .nRd_i(nRd_i), .addr_i(addr_i), .dataIn_i(dataIn_i),
    .dataOut_o(dataOut_o), .dataOe_o(dataOe_o),
    .dac0Select_i(dacSelect[0]), .dac1Select_i(dacSelect[1]), .dac2Select_i(dacSelect[2]),
    .dac0Data_i(dacData[0]), .dac1Data_i(dacData[1]), .dac2Data_i(dacData[2]),
    .tap0_i(tap[0]), .tap1_i(tap[1]), .tap2_i(tap[2]),
    .tapSync0_i(tapSync[0]), .tapSync1_i(tapSync[1]), .tapSync2_i(tapSync[2]),
    .dac0_o(dacOut[0]), .dac1_o(dacOut[1]), .dac2_o(dacOut[2]),
    .dac0Clk_o(dacClk[0]), .dac1Clk_o(dacClk[1]), .dac2Clk_o(dacClk[2]),
    .dacRst_o(dacRst_o),
    .trellisBits_i(trellisBits_i), .trellisSymEn_i(trellisSymEn_i),
    .iData_i(iData_i), .qData_i(qData_i), .dataSymEn_i(dataSymEn_i),
    .doutI_o(doutI_o), .doutQ_o(doutQ_o), .symEn_o(symEn_o),
    .bsyncLock_i(bsyncLock_i), .demodLock_i(demodLock_i),
    .bsyncNLock_o(bsyncNLock_o), .demodNLock_o(demodNLock_o)
  );

  initial begin
    ck933 = 1'b0;
    forever #50 ck933 = ~ck933;
  end

  always @(posedge ck933) begin
    cycles     <= cycles + 1;
    rstHistory <= {rstHistory[1:0], dacRst_o};
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] nextBits(input int width);
    logic [31:0] value;
    logic        feedback;
    int          b;
    value = '0;
    for (b = 0; b < width; b++) begin
      feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [`DAC_WIDTH-1:0] offsetBinary(input logic [`DAC_WIDTH-1:0] value);
    return {~value[`DAC_WIDTH-1], value[`DAC_WIDTH-2:0]};
  endfunction

  // Only the upper version half is nonzero
  function automatic logic [`BUS_WIDTH-1:0] expectedRead(input logic [`ADDR_WIDTH-1:0] addr);
    if (addr == versionUpper) begin
      return `VER_NUMBER;
    end
    return '0;
  endfunction

  //**********************************************************
  // Checks
  //**********************************************************
  logic multiH;
  logic readCycle;
  logic resetWrite;
  logic quiet;
  logic useTap [3];

  assign multiH     = (demodMode_i == modeMultiH);
  assign readCycle  = !nCs_i && !nRd_i;
  assign resetWrite = !nCs_i && !nWe_i && (addr_i == resetWord) && !dacRst_o;
  assign quiet      = !dacRst_o && (rstHistory == 3'b000);   // Core out of reset for 4 edges

  assert property (@(posedge ck933) disable iff (rs_i) dataOe_o == readCycle)
    else begin
      readErrors++;
      $display("CHECK FAILED at %0t: dataOe_o does not follow nCs_i and nRd_i", $time);
    end

  assert property (@(posedge ck933) disable iff (rs_i)
    readCycle |-> dataOut_o == expectedRead(addr_i))
    else begin
      readErrors++;
      $display("CHECK FAILED at %0t: wrong read data for address %h", $time, addr_i);
    end

  assert property (@(posedge ck933) rs_i && $past(rs_i) |-> dacRst_o && !symEn_o)
    else begin
      resetErrors++;
      $display("CHECK FAILED at %0t: wrong dacRst_o or symEn_o during reset", $time);
    end

  // Stretched reset, high from the second edge after the write
  for (genvar k = 2; k <= `RESET_HOLD + 1; k++) begin : gStretchHigh
    assert property (@(posedge ck933) disable iff (rs_i) $past(resetWrite, k) |-> dacRst_o)
      else begin
        resetErrors++;
        $display("CHECK FAILED at %0t: dacRst_o low %0d cycles after reset write", $time, k);
      end
  end

  assert property (@(posedge ck933) disable iff (rs_i)
    $past(resetWrite, `RESET_HOLD + 2) |-> !dacRst_o)
    else begin
      resetErrors++;
      $display("CHECK FAILED at %0t: dacRst_o held longer than the hold time", $time);
    end

  for (genvar ch = 0; ch < 3; ch++) begin : gDacCheck
    assign useTap[ch] = multiH && (dacSelect[ch] == dacTrellisI ||
      dacSelect[ch] == dacTrellisQ || dacSelect[ch] == dacTrellisPhErr ||
      dacSelect[ch] == dacTrellisIndex);

    assert property (@(posedge ck933) disable iff (rs_i)
      quiet && !$past(useTap[ch], 2) |-> dacOut[ch] == offsetBinary($past(dacData[ch], 3)))
      else begin
        dacErrors++;
        $display("CHECK FAILED at %0t: DAC %0d external data mismatch", $time, ch);
      end

    assert property (@(posedge ck933) disable iff (rs_i)
      quiet && $past(useTap[ch], 2) && $past(tapSync[ch], 2) |->
      dacOut[ch] == offsetBinary($past(tap[ch][`TAP_WIDTH-1 -: `DAC_WIDTH], 2)))
      else begin
        dacErrors++;
        $display("CHECK FAILED at %0t: DAC %0d tap data mismatch", $time, ch);
      end

    assert property (@(posedge ck933) disable iff (rs_i)
      quiet && $past(useTap[ch], 2) && !$past(tapSync[ch], 2) |->
      dacOut[ch] == $past(dacOut[ch], 1))
      else begin
        dacErrors++;
        $display("CHECK FAILED at %0t: DAC %0d changed without sync", $time, ch);
      end
  end

  assert property (@(posedge ck933) disable iff (rs_i)
    quiet && !$past(multiH, 1) |-> doutI_o == $past(iData_i, 3) &&
    doutQ_o == $past(qData_i, 3) && symEn_o == $past(dataSymEn_i, 3))
    else begin
      symErrors++;
      $display("CHECK FAILED at %0t: legacy symbol output mismatch", $time);
    end

  assert property (@(posedge ck933) disable iff (rs_i)
    quiet && $past(multiH, 1) |-> {doutQ_o, doutI_o} == $past(trellisBits_i, 2) &&
    symEn_o == $past(trellisSymEn_i, 2))
    else begin
      symErrors++;
      $display("CHECK FAILED at %0t: trellis symbol output mismatch", $time);
    end

  // Lock pins pass straight through
  assert property (@(posedge ck933)
    bsyncNLock_o == bsyncLock_i && demodNLock_o == demodLock_i)
    else begin
      pinErrors++;
      $display("CHECK FAILED at %0t: lock pin output does not follow its input", $time);
    end

  // DAC clocks sampled mid phase, away from both clock edges
  always @(ck933) begin
    #25;
    assert (dacClk[0] == ck933 && dacClk[1] == ck933 && dacClk[2] == ck933)
      else begin
        pinErrors++;
        $display("CHECK FAILED at %0t: DAC clock output does not follow ck933", $time);
      end
  end

  //**********************************************************
  // Stimulus
  //**********************************************************
  task automatic driveBus(input logic nCs, input logic nWe, input logic nRd,
                          input logic [`ADDR_WIDTH-1:0] addr);
    @(posedge ck933);
    #10;
    nCs_i    = nCs;
    nWe_i    = nWe;
    nRd_i    = nRd;
    addr_i   = addr;
    dataIn_i = `BUS_WIDTH'(nextBits(`BUS_WIDTH));
  endtask

  task automatic waitResetDone();
    while (dacRst_o) begin
      @(posedge ck933);
      #10;
    end
  endtask

  task automatic softResetWrite();
    driveBus(1'b0, 1'b0, 1'b1, resetWord);
    driveBus(1'b1, 1'b1, 1'b1, '0);
    while (!dacRst_o) begin
      @(posedge ck933);
      #10;
    end
    waitResetDone();
  endtask

  task automatic streamTraffic(input int count, input logic multiHRun);
    int          i;
    int          ch;
    logic [31:0] pick;
    for (i = 0; i < count; i++) begin
      @(posedge ck933);
      #10;
      pick = nextBits(3);
      if (multiHRun) begin
        demodMode_i = (pick == 0) ? modeLegacy : modeMultiH;           // Short legacy spells
      end else begin
        demodMode_i = (pick == 0) ? demodMode_t'(4'h3) : modeLegacy;   // Unknown code
      end
      for (ch = 0; ch < 3; ch++) begin
        pick          = nextBits(3);
        dacSelect[ch] = dacSelect_t'((pick > 4) ? 4'h0 : pick[3:0]);
        dacData[ch]   = `DAC_WIDTH'(nextBits(`DAC_WIDTH));
        tap[ch]       = `TAP_WIDTH'(nextBits(`TAP_WIDTH));
        tapSync[ch]   = 1'(nextBits(1));
      end
      trellisBits_i  = 2'(nextBits(2));
      trellisSymEn_i = 1'(nextBits(1));
      iData_i        = 1'(nextBits(1));
      qData_i        = 1'(nextBits(1));
      dataSymEn_i    = 1'(nextBits(1));
      bsyncLock_i    = 1'(nextBits(1));
      demodLock_i    = 1'(nextBits(1));
    end
  endtask

  initial begin
    int                     i;
    logic [`ADDR_WIDTH-1:0] addr;
    lfsrState   = 16'd6;
    rs_i        = 1'b1;
    demodMode_i = modeLegacy;
    nCs_i       = 1'b1;
    nWe_i       = 1'b1;
    nRd_i       = 1'b1;
    addr_i      = '0;
    dataIn_i    = '0;
    for (i = 0; i < 3; i++) begin
      dacSelect[i] = dacExternal;
      dacData[i]   = '0;
      tap[i]       = '0;
      tapSync[i]   = 1'b0;
    end
    trellisBits_i  = 2'b00;
    trellisSymEn_i = 1'b0;
    iData_i        = 1'b0;
    qData_i        = 1'b0;
    dataSymEn_i    = 1'b0;
    bsyncLock_i    = 1'b0;
    demodLock_i    = 1'b0;

    repeat (10) @(posedge ck933);
    #10;
    rs_i = 1'b0;
    waitResetDone();

    // Version halves, chip select and read strobe combinations
    driveBus(1'b0, 1'b1, 1'b0, versionUpper);
    driveBus(1'b0, 1'b1, 1'b0, versionLower);
    driveBus(1'b1, 1'b1, 1'b0, versionUpper);
    driveBus(1'b0, 1'b1, 1'b1, versionUpper);
    for (i = 0; i < 8; i++) begin
      addr = `ADDR_WIDTH'(nextBits(`ADDR_WIDTH));
      if (addr[`ADDR_WIDTH-1 -: 4] == `MISC_SPACE) begin
        addr[`ADDR_WIDTH-1] = 1'b0;   // Keep clear of the misc space
      end
      driveBus(1'b0, 1'b1, 1'b0, addr);
    end
    driveBus(1'b1, 1'b1, 1'b1, '0);

    streamTraffic(80, 1'b0);
    streamTraffic(160, 1'b1);
    softResetWrite();
    streamTraffic(30, 1'b1);
    softResetWrite();
    repeat (4) @(posedge ck933);

    $display("Errors: read %0d, reset %0d, DAC %0d, symbol %0d, pins %0d",
             readErrors, resetErrors, dacErrors, symErrors, pinErrors);
    if (readErrors + resetErrors + dacErrors + symErrors + pinErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycles == cycleLimit);
    $display("Timeout after %0d cycles, the test sequence did not complete", cycleLimit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/demodPkg.sv
hw/hostBus.sv
hw/resetStretch.sv
hw/dacOutput.sv
hw/symbolSource.sv
hw/multihTop.sv
verification/multihTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the multihTop testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module multihTopTb -f sim.f -o multihTopSim
./obj_dir/multihTopSim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
